// ==== bench/tb_tag_link.sv ====
/*
 * Testbench for the time tag receiver
 * Streams random tag beats into the DUT, keeps a reference histogram
 * and checks registers and every bin over Wishbone
 */
`timescale 1ns/10ps

module tb_tag_link import tagger_pkg::*; ();

    localparam int WORD_WIDTH = 4;
    localparam int NUM_BINS   = 256;
    localparam int NUM_BEATS  = 300;
    // Two 300-beat runs at up to 16 cycles a beat, five full bin sweeps
    // of about 5 cycles per read, plus clears and drain waits
    localparam int TIMEOUT_CYCLES = 40000;

    // Run configuration, start on a rising edge and click on a falling one
    localparam logic [CHANNEL_BITS-1:0] START_CH = 6'd3;
    localparam logic [CHANNEL_BITS-1:0] CLICK_CH = 6'h3b;
    localparam int BIN_SHIFT = 17;
    localparam int BURST_BIN = 37;

    logic                       sys_clk;
    logic                       sys_clk_rst;
    logic                       tag_valid_i;
    logic                       tag_ready_o;
    tag_word_u [WORD_WIDTH-1:0] tag_data_i;
    logic [WORD_WIDTH-1:0]      tag_keep_i;
    logic                       wb_cyc_i;
    logic                       wb_stb_i;
    logic                       wb_we_i;
    logic [WB_ADDR_BITS-1:0]    wb_adr_i;
    logic [31:0]                wb_dat_i;
    logic [31:0]                wb_dat_o;
    logic                       wb_ack_o;

    integer seed = 32'hf4e6_8aa0;
    int     cycle_count = 0;
    logic   streaming;

    // Reference model state, persists across tests like the DUT
    logic [WRAP_BITS-1:0]  gen_wrap;
    logic [WRAP_BITS-1:0]  model_wrap;
    tag_time_t             model_start;
    logic                  model_start_seen;
    logic [COUNT_BITS-1:0] model_bins [NUM_BINS];

    tag_link_top #(.WORD_WIDTH(WORD_WIDTH), .NUM_BINS(NUM_BINS)) dut0 (
        .sys_clk(sys_clk), .sys_clk_rst(sys_clk_rst),
        .tag_valid_i(tag_valid_i), .tag_ready_o(tag_ready_o),
        .tag_data_i(tag_data_i), .tag_keep_i(tag_keep_i),
        .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
        .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
        .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o)
    );

    initial begin
        sys_clk = 1'b0;
        forever #5 sys_clk = ~sys_clk;
    end

    task automatic fail_run();
        $display("TEST FAILED");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            $display("Error at %0t ns: %s read 0x%08h, expected 0x%08h",
                     $time, what, got, expected);
            fail_run();
        end
    endtask

    // Run length guard
    always @(posedge sys_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("simulation timed out after %0d cycles", cycle_count);
            fail_run();
        end
    end

    // Ack must stay low while reset is held
    always @(negedge sys_clk) begin
        if (sys_clk_rst) begin
            assert (wb_ack_o === 1'b0) else begin
                $display("Error at %0t ns: wb_ack_o high during reset", $time);
                fail_run();
            end
        end
    end

    // Drop cyc/stb right after the ack cycle
    task automatic wait_for_ack();
        do begin
            @(posedge sys_clk);
            #1;
        end while (!wb_ack_o);
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic bus_write(input logic [WB_ADDR_BITS-1:0] addr, input logic [31:0] data);
        @(posedge sys_clk);
        #1;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = 1'b1;
        wb_adr_i = addr;
        wb_dat_i = data;
        wait_for_ack();
    endtask

    task automatic bus_read(input logic [WB_ADDR_BITS-1:0] addr, output logic [31:0] data);
        @(posedge sys_clk);
        #1;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = 1'b0;
        wb_adr_i = addr;
        wait_for_ack();
        data = wb_dat_o;
    endtask

    function automatic logic [WB_ADDR_BITS-1:0] bin_addr(input int bin);
        return (WB_ADDR_BITS'(1) << BIN_REGION_BIT) | WB_ADDR_BITS'(bin);
    endfunction

    function automatic tag_word_u event_word(input logic [CHANNEL_BITS-1:0] ch,
                                             input logic [SUBTIME_BITS-1:0] sub);
        tag_word_u word;
        word.evt.marker  = 1'b0;
        word.evt.channel = ch;
        word.evt.subtime = sub;
        return word;
    endfunction

    // Timestamp is wrap count times 2^SUBTIME_BITS plus subtime
    task automatic model_beat(input tag_word_u [WORD_WIDTH-1:0] data,
                              input logic [WORD_WIDTH-1:0] keep);
        tag_time_t stamp;
        tag_time_t offset;
        for (int i = 0; i < WORD_WIDTH; i++) begin
            if (keep[i] && data[i].wrap.marker) begin
                model_wrap = data[i].wrap.wrap_count;
            end else if (keep[i]) begin
                stamp = 64'(model_wrap) * (64'd1 << SUBTIME_BITS)
                        + 64'(data[i].evt.subtime);
                // Click is timed against the start before it
                if (data[i].evt.channel == CLICK_CH && model_start_seen) begin
                    offset = (stamp - model_start) >> BIN_SHIFT;
                    if (offset < 64'(NUM_BINS)) begin
                        model_bins[int'(offset)] = model_bins[int'(offset)] + 1'b1;
                    end
                end
                if (data[i].evt.channel == START_CH) begin
                    model_start      = stamp;
                    model_start_seen = 1'b1;
                end
            end
        end
    endtask

    // Lane mix: dropped, wrap marker, start, click, other channel
    task automatic make_beat(output tag_word_u [WORD_WIDTH-1:0] data,
                             output logic [WORD_WIDTH-1:0] keep);
        int kind;
        logic [SUBTIME_BITS-1:0] sub;
        for (int i = 0; i < WORD_WIDTH; i++) begin
            kind    = int'($unsigned($random(seed)) % 8);
            sub     = SUBTIME_BITS'($random(seed));
            keep[i] = (kind != 0);
            data[i] = $random(seed);
            case (kind)
                1: begin
                    gen_wrap = gen_wrap + 1'b1;
                    data[i].wrap.marker     = 1'b1;
                    data[i].wrap.wrap_count = gen_wrap;
                end
                2, 3: data[i] = event_word(START_CH, sub);
                4, 5: data[i] = event_word(CLICK_CH, sub);
                // Neighbours of both channels, either polarity
                6: data[i] = event_word(6'h3d, sub);
                7: data[i] = event_word(6'd5, sub);
                default: ;
            endcase
        end
    endtask

    // Called 1 ns after an edge, returns 1 ns after the transfer edge
    task automatic send_beat(input tag_word_u [WORD_WIDTH-1:0] data,
                             input logic [WORD_WIDTH-1:0] keep);
        tag_valid_i = 1'b1;
        tag_data_i  = data;
        tag_keep_i  = keep;
        while (!tag_ready_o) begin
            @(posedge sys_clk);
            #1;
        end
        @(posedge sys_clk);
        #1;
        tag_valid_i = 1'b0;
        model_beat(data, keep);
    endtask

    task automatic stream_beats(input int count, input bit gaps);
        tag_word_u [WORD_WIDTH-1:0] data;
        logic [WORD_WIDTH-1:0]      keep;
        int idle;
        for (int n = 0; n < count; n++) begin
            make_beat(data, keep);
            send_beat(data, keep);
            if (gaps) begin
                idle = int'($unsigned($random(seed)) % 4);
                repeat (idle) begin
                    @(posedge sys_clk);
                    #1;
                end
            end
        end
    endtask

    task automatic clear_bins();
        logic [31:0] status;
        bus_write(REG_CONTROL, 32'd1);
        do begin
            bus_read(REG_CONTROL, status);
        end while (status[0]);
        for (int b = 0; b < NUM_BINS; b++) begin
            model_bins[b] = '0;
        end
    endtask

    task automatic check_all_bins();
        logic [31:0] value;
        for (int b = 0; b < NUM_BINS; b++) begin
            bus_read(bin_addr(b), value);
            check_value($sformatf("bin %0d", b), value, model_bins[b]);
        end
    endtask

    task automatic drain();
        repeat (200) @(posedge sys_clk);
        #1;
    endtask

    initial begin
        logic [31:0]                value;
        logic [31:0]                sweep_value;
        int                         sweep_bin;
        int                         clicks;
        tag_word_u [WORD_WIDTH-1:0] data;
        logic [SUBTIME_BITS-1:0]    base;

        sys_clk_rst      = 1'b1;
        tag_valid_i      = 1'b0;
        tag_data_i       = '0;
        tag_keep_i       = '0;
        wb_cyc_i         = 1'b0;
        wb_stb_i         = 1'b0;
        wb_we_i          = 1'b0;
        wb_adr_i         = '0;
        wb_dat_i         = '0;
        streaming        = 1'b0;
        gen_wrap         = '0;
        model_wrap       = '0;
        model_start      = '0;
        model_start_seen = 1'b0;
        for (int b = 0; b < NUM_BINS; b++) begin
            model_bins[b] = '0;
        end
        repeat (16) @(posedge sys_clk);
        #1;
        sys_clk_rst = 1'b0;
        check_value("tag_ready_o after reset", 32'(tag_ready_o), 32'd1);

        // Identity and size words
        bus_read(REG_ID, value);
        check_value("REG_ID", value, 32'd1);
        bus_read(REG_NUM_BINS, value);
        check_value("REG_NUM_BINS", value, 32'(NUM_BINS));

        // Scratch values first, then the run configuration
        bus_write(REG_START_CH, 32'h2a);
        bus_write(REG_CLICK_CH, 32'h15);
        bus_write(REG_BIN_SHIFT, 32'd9);
        bus_read(REG_START_CH, value);
        check_value("REG_START_CH", value, 32'h2a);
        bus_read(REG_CLICK_CH, value);
        check_value("REG_CLICK_CH", value, 32'h15);
        bus_read(REG_BIN_SHIFT, value);
        check_value("REG_BIN_SHIFT", value, 32'd9);
        bus_write(REG_START_CH, 32'(START_CH));
        bus_write(REG_CLICK_CH, 32'(CLICK_CH));
        bus_write(REG_BIN_SHIFT, 32'(BIN_SHIFT));
        bus_read(REG_CLICK_CH, value);
        check_value("REG_CLICK_CH", value, 32'(CLICK_CH));
        // Unknown address takes the write and still reads 0
        bus_write(12'h07f, 32'hdead_beef);
        bus_read(12'h07f, value);
        check_value("unknown address", value, 32'd0);

        clear_bins();
        check_all_bins();

        // Clicks ahead of any start, then the random stream
        for (int i = 0; i < WORD_WIDTH; i++) begin
            data[i] = event_word(CLICK_CH, SUBTIME_BITS'($random(seed)));
        end
        send_beat(data, '1);
        stream_beats(NUM_BEATS, 1'b0);
        drain();
        check_all_bins();

        // Gapped stream with a bin sweep running on the bus
        clear_bins();
        streaming = 1'b1;
        sweep_bin = 0;
        fork
            begin
                stream_beats(NUM_BEATS, 1'b1);
                streaming = 1'b0;
            end
            begin
                while (streaming) begin
                    bus_read(bin_addr(sweep_bin), sweep_value);
                    // A count read mid-stream can only trail the model
                    assert (sweep_value <= model_bins[sweep_bin]) else begin
                        $display("Error at %0t ns: bin %0d read %0d mid-stream, model has %0d",
                                 $time, sweep_bin, sweep_value, model_bins[sweep_bin]);
                        fail_run();
                    end
                    sweep_bin = (sweep_bin + 1) % NUM_BINS;
                end
            end
        join
        drain();
        check_all_bins();

        // Start then three clicks per beat, all in one bin
        clear_bins();
        clicks = 0;
        for (int n = 0; n < 40; n++) begin
            base    = SUBTIME_BITS'($unsigned($random(seed)) % (1 << 24));
            data[0] = event_word(START_CH, base);
            for (int i = 1; i < WORD_WIDTH; i++) begin
                data[i] = event_word(CLICK_CH, base + SUBTIME_BITS'(BURST_BIN << BIN_SHIFT)
                          + SUBTIME_BITS'($unsigned($random(seed)) % (1 << BIN_SHIFT)));
                clicks++;
            end
            send_beat(data, '1);
        end
        drain();
        bus_read(bin_addr(BURST_BIN), value);
        check_value("burst bin", value, 32'(clicks));
        check_all_bins();

        $display("TEST OK");
        $finish;
    end

endmodule

// ==== hdl/bin_memory_arbiter.sv ====
/*
 * Bin memory arbiter
 * Owns the histogram counts; serves clear walks, bus reads and
 * read-modify-write increments in that order of priority
 */
`timescale 1ns/10ps

module bin_memory_arbiter import tagger_pkg::*; #(
    parameter int NUM_BINS = 256
) (
    input  logic                        sys_clk,
    input  logic                        sys_clk_rst,
    input  logic                        inc_req_i,
    input  logic [$clog2(NUM_BINS)-1:0] inc_bin_i,
    output logic                        inc_grant_o,
    input  logic                        rd_req_i,
    input  logic [$clog2(NUM_BINS)-1:0] rd_bin_i,
    output logic                        rd_grant_o,
    output logic                        rd_done_o,
    output logic [COUNT_BITS-1:0]       rd_data_o,
    input  logic                        clear_i,
    output logic                        clear_busy_o
);

    localparam int BIN_BITS = $clog2(NUM_BINS);

    logic [COUNT_BITS-1:0] mem [NUM_BINS];

    logic [BIN_BITS-1:0]   clr_addr_q;
    // Increment write-back stage
    logic                  wb_valid_q;
    logic [BIN_BITS-1:0]   wb_bin_q;
    logic [COUNT_BITS-1:0] wb_data_q;

    logic [BIN_BITS-1:0]   rd_addr;
    logic [COUNT_BITS-1:0] cur_count;

    // Clear walk blocks everyone, bus read beats increment
    assign rd_grant_o  = !clear_busy_o && rd_req_i;
    assign inc_grant_o = !clear_busy_o && !rd_req_i && inc_req_i;

    // One read port shared by both users
    assign rd_addr = rd_grant_o ? rd_bin_i : inc_bin_i;
    // Pending write-back to the same bin is newer than memory
    assign cur_count = (wb_valid_q && wb_bin_q == rd_addr) ? wb_data_q : mem[rd_addr];

    always_ff @(posedge sys_clk) begin
        if (sys_clk_rst) begin
            clear_busy_o <= 1'b0;
            clr_addr_q   <= '0;
            wb_valid_q   <= 1'b0;
            rd_done_o    <= 1'b0;
        end else begin
            wb_valid_q <= inc_grant_o;
            rd_done_o  <= rd_grant_o;
            if (clear_i && !clear_busy_o) begin
                clear_busy_o <= 1'b1;
                clr_addr_q   <= '0;
            end else if (clear_busy_o) begin
                clr_addr_q <= clr_addr_q + 1'b1;
                if (clr_addr_q == BIN_BITS'(NUM_BINS - 1)) begin
                    clear_busy_o <= 1'b0;
                end
            end
        end
    end

    // Payload and memory
    always_ff @(posedge sys_clk) begin
        if (inc_grant_o) begin
            wb_bin_q  <= inc_bin_i;
            wb_data_q <= cur_count + 1'b1;
        end
        if (rd_grant_o) begin
            rd_data_o <= cur_count;
        end
        // Clear write wins over a stray write-back in its first cycle
        if (clear_busy_o) begin
            mem[clr_addr_q] <= '0;
        end else if (wb_valid_q) begin
            mem[wb_bin_q] <= wb_data_q;
        end
    end

    assert property (@(posedge sys_clk) disable iff (sys_clk_rst)
        $onehot0({inc_grant_o, rd_grant_o}))
        else $error("more than one grant");

    // Nothing granted, and nothing landing once the walk is past its first bin
    assert property (@(posedge sys_clk) disable iff (sys_clk_rst)
        clear_busy_o |-> !inc_grant_o && !rd_grant_o
            && (clr_addr_q == '0 || (!wb_valid_q && !rd_done_o)))
        else $error("grant during clear");

endmodule

// ==== hdl/histogram_binner.sv ====
/*
 * Start-to-click histogram binner
 * Walks the kept lanes of each beat, times clicks against the last start
 * and asks the arbiter to increment the matching bin
 */
`timescale 1ns/10ps

module histogram_binner import tagger_pkg::*; #(
    parameter int WORD_WIDTH = 4,
    parameter int NUM_BINS   = 256
) (
    input  logic                                    sys_clk,
    input  logic                                    sys_clk_rst,
    input  logic                                    s_valid_i,
    output logic                                    s_ready_o,
    input  tag_time_t [WORD_WIDTH-1:0]              s_time_i,
    input  logic [WORD_WIDTH-1:0][CHANNEL_BITS-1:0] s_channel_i,
    input  logic [WORD_WIDTH-1:0]                   s_keep_i,
    input  logic [CHANNEL_BITS-1:0]                 start_channel_i,
    input  logic [CHANNEL_BITS-1:0]                 click_channel_i,
    input  logic [SHIFT_BITS-1:0]                   bin_shift_i,
    output logic                                    inc_req_o,
    output logic [$clog2(NUM_BINS)-1:0]             inc_bin_o,
    input  logic                                    inc_grant_i
);

    localparam int BIN_BITS = $clog2(NUM_BINS);

    // Held beat, pend_q marks lanes still to walk
    tag_time_t [WORD_WIDTH-1:0]             time_q;
    logic [WORD_WIDTH-1:0][CHANNEL_BITS-1:0] chan_q;
    logic [WORD_WIDTH-1:0]                  pend_q;

    // Last start seen
    tag_time_t start_time_q;
    logic      start_seen_q;

    logic [WORD_WIDTH-1:0]   lane_oh;
    tag_time_t               cur_time;
    logic [CHANNEL_BITS-1:0] cur_chan;
    tag_time_t               delta;
    logic                    advance;
    logic                    last_lane;
    logic                    hit;

    // Lowest pending lane
    always_comb begin
        lane_oh  = pend_q & (~pend_q + 1'b1);
        cur_time = '0;
        cur_chan = '0;
        for (int i = 0; i < WORD_WIDTH; i++) begin
            if (lane_oh[i]) begin
                cur_time = time_q[i];
                cur_chan = chan_q[i];
            end
        end
    end

    // Stall only while an earlier increment waits for its grant
    assign advance   = (pend_q != '0) && (!inc_req_o || inc_grant_i);
    assign last_lane = (pend_q & ~lane_oh) == '0;
    assign s_ready_o = (pend_q == '0) || (advance && last_lane);

    // Click minus start, scaled down into bin units
    assign delta = (cur_time - start_time_q) >> bin_shift_i;
    assign hit   = (cur_chan == click_channel_i) && start_seen_q
                   && (delta < 64'(NUM_BINS));

    always_ff @(posedge sys_clk) begin
        if (sys_clk_rst) begin
            pend_q       <= '0;
            start_seen_q <= 1'b0;
            inc_req_o    <= 1'b0;
        end else begin
            if (inc_grant_i) begin
                inc_req_o <= 1'b0;
            end
            if (advance) begin
                // Click uses the start from before this lane
                if (hit) begin
                    inc_req_o <= 1'b1;
                end
                if (cur_chan == start_channel_i) begin
                    start_seen_q <= 1'b1;
                end
            end
            if (s_valid_i && s_ready_o) begin
                pend_q <= s_keep_i;
            end else if (advance) begin
                pend_q <= pend_q & ~lane_oh;
            end
        end
    end

    // Payload registers
    always_ff @(posedge sys_clk) begin
        if (advance && hit) begin
            inc_bin_o <= delta[BIN_BITS-1:0];
        end
        if (advance && cur_chan == start_channel_i) begin
            start_time_q <= cur_time;
        end
        if (s_valid_i && s_ready_o) begin
            time_q <= s_time_i;
            chan_q <= s_channel_i;
        end
    end

endmodule

// ==== hdl/tag_converter.sv ====
/*
 * Tag converter
 * Turns each beat of 32-bit tag words into 64-bit timestamps per lane,
 * following wrap markers to extend the time base
 */
`timescale 1ns/10ps

module tag_converter import tagger_pkg::*; #(
    parameter int WORD_WIDTH = 4
) (
    input  logic                                    sys_clk,
    input  logic                                    sys_clk_rst,
    input  logic                                    s_valid_i,
    output logic                                    s_ready_o,
    input  tag_word_u [WORD_WIDTH-1:0]              s_data_i,
    input  logic [WORD_WIDTH-1:0]                   s_keep_i,
    output logic                                    m_valid_o,
    input  logic                                    m_ready_i,
    output tag_time_t [WORD_WIDTH-1:0]              m_time_o,
    output logic [WORD_WIDTH-1:0][CHANNEL_BITS-1:0] m_channel_o,
    output logic [WORD_WIDTH-1:0]                   m_keep_o
);

    // Wrap count in effect after the last accepted beat
    logic [WRAP_BITS-1:0] wrap_q;
    logic [WRAP_BITS-1:0] wrap_run;

    tag_time_t [WORD_WIDTH-1:0]             lane_time;
    logic [WORD_WIDTH-1:0][CHANNEL_BITS-1:0] lane_channel;
    logic [WORD_WIDTH-1:0]                  lane_keep;
    logic                                   accept;

    // Output register is free when empty or drained this cycle
    assign s_ready_o = !m_valid_o || m_ready_i;
    assign accept    = s_valid_i && s_ready_o;

    // Lanes in order, a marker applies to every later lane
    always_comb begin
        wrap_run = wrap_q;
        for (int i = 0; i < WORD_WIDTH; i++) begin
            lane_time[i]    = '0;
            lane_channel[i] = s_data_i[i].evt.channel;
            lane_keep[i]    = 1'b0;
            if (s_keep_i[i]) begin
                if (s_data_i[i].wrap.marker) begin
                    wrap_run = s_data_i[i].wrap.wrap_count;
                end else begin
                    // Wrap count above the subtime, zero padded to 64 bits
                    lane_time[i] = {8'd0, wrap_run, s_data_i[i].evt.subtime};
                    lane_keep[i] = 1'b1;
                end
            end
        end
    end

    // Control state
    always_ff @(posedge sys_clk) begin
        if (sys_clk_rst) begin
            m_valid_o <= 1'b0;
            wrap_q    <= '0;
        end else if (accept) begin
            m_valid_o <= 1'b1;
            wrap_q    <= wrap_run;
        end else if (m_ready_i) begin
            m_valid_o <= 1'b0;
        end
    end

    // Payload, only loaded on accept
    always_ff @(posedge sys_clk) begin
        if (accept) begin
            m_time_o    <= lane_time;
            m_channel_o <= lane_channel;
            m_keep_o    <= lane_keep;
        end
    end

    // Held beat must not change under back-pressure
    assert property (@(posedge sys_clk) disable iff (sys_clk_rst)
        m_valid_o && !m_ready_i |=> m_valid_o && $stable(m_time_o)
            && $stable(m_channel_o) && $stable(m_keep_o))
        else $error("converter output changed while stalled");

endmodule

// ==== hdl/tag_link_top.sv ====
/*
 * Time tag receiver top level
 * Tag converter feeding the start-to-click binner, plus the Wishbone target,
 * both sharing one bin memory through the arbiter
 */
`timescale 1ns/10ps

module tag_link_top import tagger_pkg::*; #(
    parameter int WORD_WIDTH = 4,
    parameter int NUM_BINS   = 256
) (
    input  logic                               sys_clk,
    input  logic                               sys_clk_rst,
    // Tag stream from the link
    input  logic                               tag_valid_i,
    output logic                               tag_ready_o,
    input  tag_word_u [WORD_WIDTH-1:0]         tag_data_i,
    input  logic [WORD_WIDTH-1:0]              tag_keep_i,
    // Wishbone target
    input  logic                               wb_cyc_i,
    input  logic                               wb_stb_i,
    input  logic                               wb_we_i,
    input  logic [WB_ADDR_BITS-1:0]            wb_adr_i,
    input  logic [31:0]                        wb_dat_i,
    output logic [31:0]                        wb_dat_o,
    output logic                               wb_ack_o
);

    localparam int BIN_BITS = $clog2(NUM_BINS);

    // Converter to binner stream
    logic                                   conv_valid;
    logic                                   conv_ready;
    tag_time_t [WORD_WIDTH-1:0]             conv_time;
    logic [WORD_WIDTH-1:0][CHANNEL_BITS-1:0] conv_channel;
    logic [WORD_WIDTH-1:0]                  conv_keep;

    // Control registers
    logic [CHANNEL_BITS-1:0] start_channel;
    logic [CHANNEL_BITS-1:0] click_channel;
    logic [SHIFT_BITS-1:0]   bin_shift;

    // Arbiter requesters
    logic                  inc_req;
    logic [BIN_BITS-1:0]   inc_bin;
    logic                  inc_grant;
    logic                  rd_req;
    logic [BIN_BITS-1:0]   rd_bin;
    logic                  rd_grant;
    logic                  rd_done;
    logic [COUNT_BITS-1:0] rd_data;
    logic                  clear;
    logic                  clear_busy;

    tag_converter #(.WORD_WIDTH(WORD_WIDTH)) converter0 (
        .sys_clk(sys_clk), .sys_clk_rst(sys_clk_rst),
        .s_valid_i(tag_valid_i), .s_ready_o(tag_ready_o),
        .s_data_i(tag_data_i), .s_keep_i(tag_keep_i),
        .m_valid_o(conv_valid), .m_ready_i(conv_ready),
        .m_time_o(conv_time), .m_channel_o(conv_channel), .m_keep_o(conv_keep)
    );

    histogram_binner #(.WORD_WIDTH(WORD_WIDTH), .NUM_BINS(NUM_BINS)) binner0 (
        .sys_clk(sys_clk), .sys_clk_rst(sys_clk_rst),
        .s_valid_i(conv_valid), .s_ready_o(conv_ready),
        .s_time_i(conv_time), .s_channel_i(conv_channel), .s_keep_i(conv_keep),
        .start_channel_i(start_channel), .click_channel_i(click_channel),
        .bin_shift_i(bin_shift),
        .inc_req_o(inc_req), .inc_bin_o(inc_bin), .inc_grant_i(inc_grant)
    );

    bin_memory_arbiter #(.NUM_BINS(NUM_BINS)) arbiter0 (
        .sys_clk(sys_clk), .sys_clk_rst(sys_clk_rst),
        .inc_req_i(inc_req), .inc_bin_i(inc_bin), .inc_grant_o(inc_grant),
        .rd_req_i(rd_req), .rd_bin_i(rd_bin), .rd_grant_o(rd_grant),
        .rd_done_o(rd_done), .rd_data_o(rd_data),
        .clear_i(clear), .clear_busy_o(clear_busy)
    );

    wb_register_target #(.NUM_BINS(NUM_BINS)) target0 (
        .sys_clk(sys_clk), .sys_clk_rst(sys_clk_rst),
        .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
        .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
        .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
        .start_channel_o(start_channel), .click_channel_o(click_channel),
        .bin_shift_o(bin_shift),
        .rd_req_o(rd_req), .rd_bin_o(rd_bin), .rd_grant_i(rd_grant),
        .rd_done_i(rd_done), .rd_data_i(rd_data),
        .clear_o(clear), .clear_busy_i(clear_busy)
    );

endmodule

// ==== hdl/tagger_pkg.sv ====
/*
 * Shared definitions for the FPGA-link time tag receiver
 * Tag word layouts, timestamp type and the register map
 */
package tagger_pkg;

    // Tag word geometry
    localparam int TAG_WORD_BITS = 32;
    localparam int CHANNEL_BITS  = 6;
    localparam int SUBTIME_BITS  = 25;
    localparam int WRAP_BITS     = 31;

    // Timestamp in units of 1/3 ps, wrap count above the subtime
    typedef logic [63:0] tag_time_t;

    // Event word, marker clear
    // Negative channel means falling edge
    typedef struct packed {
        logic                     marker;
        logic [CHANNEL_BITS-1:0]  channel;
        logic [SUBTIME_BITS-1:0]  subtime;
    } tag_event_t;

    // Wrap marker word, marker set, carries the new absolute wrap count
    typedef struct packed {
        logic                  marker;
        logic [WRAP_BITS-1:0]  wrap_count;
    } wrap_marker_t;

    // One tag word, decoded by its top bit
    typedef union packed {
        tag_event_t    evt;
        wrap_marker_t  wrap;
    } tag_word_u;

    // Wishbone register map, word addresses
    localparam int WB_ADDR_BITS = 12;
    localparam logic [WB_ADDR_BITS-1:0] REG_ID        = 12'd0;
    localparam logic [WB_ADDR_BITS-1:0] REG_NUM_BINS  = 12'd1;
    localparam logic [WB_ADDR_BITS-1:0] REG_START_CH  = 12'd2;
    localparam logic [WB_ADDR_BITS-1:0] REG_CLICK_CH  = 12'd3;
    localparam logic [WB_ADDR_BITS-1:0] REG_BIN_SHIFT = 12'd4;
    localparam logic [WB_ADDR_BITS-1:0] REG_CONTROL   = 12'd5;
    // Set for the bin window, low bits pick the bin
    localparam int BIN_REGION_BIT = 11;

    localparam logic [31:0] DESIGN_ID = 32'd1;
    localparam int COUNT_BITS = 32;
    // Width of the bin shift register field
    localparam int SHIFT_BITS = 6;

endpackage

// ==== hdl/wb_register_target.sv ====
/*
 * Wishbone register target
 * One-cycle ack for control registers, bin reads forwarded to the
 * arbiter and acked once their data returns
 */
`timescale 1ns/10ps

module wb_register_target import tagger_pkg::*; #(
    parameter int NUM_BINS = 256
) (
    input  logic                        sys_clk,
    input  logic                        sys_clk_rst,
    input  logic                        wb_cyc_i,
    input  logic                        wb_stb_i,
    input  logic                        wb_we_i,
    input  logic [WB_ADDR_BITS-1:0]     wb_adr_i,
    input  logic [31:0]                 wb_dat_i,
    output logic [31:0]                 wb_dat_o,
    output logic                        wb_ack_o,
    output logic [CHANNEL_BITS-1:0]     start_channel_o,
    output logic [CHANNEL_BITS-1:0]     click_channel_o,
    output logic [SHIFT_BITS-1:0]       bin_shift_o,
    output logic                        rd_req_o,
    output logic [$clog2(NUM_BINS)-1:0] rd_bin_o,
    input  logic                        rd_grant_i,
    input  logic                        rd_done_i,
    input  logic [COUNT_BITS-1:0]       rd_data_i,
    output logic                        clear_o,
    input  logic                        clear_busy_i
);

    localparam int BIN_BITS = $clog2(NUM_BINS);

    // Bin read in progress, no new request until its ack
    logic rd_busy_q;
    logic req;
    logic bin_read;

    // New request only while not acking and not waiting on a bin
    assign req      = wb_cyc_i && wb_stb_i && !wb_ack_o && !rd_busy_q;
    assign bin_read = wb_adr_i[BIN_REGION_BIT] && !wb_we_i;

    always_ff @(posedge sys_clk) begin
        if (sys_clk_rst) begin
            wb_ack_o        <= 1'b0;
            rd_busy_q       <= 1'b0;
            rd_req_o        <= 1'b0;
            clear_o         <= 1'b0;
            start_channel_o <= '0;
            click_channel_o <= '0;
            bin_shift_o     <= '0;
        end else begin
            wb_ack_o <= 1'b0;
            clear_o  <= 1'b0;
            if (rd_grant_i) begin
                rd_req_o <= 1'b0;
            end
            if (rd_done_i) begin
                wb_ack_o  <= 1'b1;
                rd_busy_q <= 1'b0;
            end else if (req && bin_read) begin
                rd_req_o  <= 1'b1;
                rd_busy_q <= 1'b1;
            end else if (req) begin
                wb_ack_o <= 1'b1;
                // Writes to bins or unknown addresses fall through
                if (wb_we_i) begin
                    case (wb_adr_i)
                        REG_START_CH:  start_channel_o <= wb_dat_i[CHANNEL_BITS-1:0];
                        REG_CLICK_CH:  click_channel_o <= wb_dat_i[CHANNEL_BITS-1:0];
                        REG_BIN_SHIFT: bin_shift_o     <= wb_dat_i[SHIFT_BITS-1:0];
                        REG_CONTROL:   clear_o         <= wb_dat_i[0];
                        default: ;
                    endcase
                end
            end
        end
    end

    // Read data and bin address
    always_ff @(posedge sys_clk) begin
        if (rd_done_i) begin
            wb_dat_o <= rd_data_i;
        end else if (req && bin_read) begin
            rd_bin_o <= wb_adr_i[BIN_BITS-1:0];
        end else if (req && !wb_we_i) begin
            case (wb_adr_i)
                REG_ID:        wb_dat_o <= DESIGN_ID;
                REG_NUM_BINS:  wb_dat_o <= 32'(NUM_BINS);
                REG_START_CH:  wb_dat_o <= 32'(start_channel_o);
                REG_CLICK_CH:  wb_dat_o <= 32'(click_channel_o);
                REG_BIN_SHIFT: wb_dat_o <= 32'(bin_shift_o);
                REG_CONTROL:   wb_dat_o <= {31'd0, clear_busy_i};
                default:       wb_dat_o <= '0;
            endcase
        end
    end

    // Ack is a single-cycle pulse
    assert property (@(posedge sys_clk) disable iff (sys_clk_rst)
        wb_ack_o |=> !wb_ack_o)
        else $error("ack held for two cycles");

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the tag link testbench with Verilator
# Exit status is the simulator's, nonzero on any failure

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal \
    --top-module tb_tag_link --Mdir obj_dir -o tb_tag_link \
    -f tag_link.f
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit "$build_status"
fi

./obj_dir/tb_tag_link
run_status=$?
if [ "$run_status" -ne 0 ]; then
    echo "Simulation failed with status $run_status"
fi
exit "$run_status"

// ==== tag_link.f ====
hdl/tagger_pkg.sv
hdl/tag_converter.sv
hdl/histogram_binner.sv
hdl/bin_memory_arbiter.sv
hdl/wb_register_target.sv
hdl/tag_link_top.sv
bench/tb_tag_link.sv
